/* hdl/snd_pkg.sv */
/* Shared sample widths, gain constants and channel structs for the sound board.
   Modules import this package to connect the conditioning blocks and the mixer. */
package snd_pkg;

    typedef logic signed [15:0] smp16_t;   // mixed / scaled audio sample
    typedef logic signed [13:0] pcm14_t;   // raw ADPCM output
    typedef logic        [ 9:0] psg10_t;   // raw PSG output, unsigned
    typedef logic signed [10:0] psg_ac_t;  // PSG after DC removal
    typedef logic        [ 7:0] gain_t;    // 4.4 fixed point, 0x10 is unity

    localparam gain_t OPL_GAIN = 8'h10;
    localparam gain_t PCM_GAIN = 8'h10;
    localparam gain_t PSG_GAIN = 8'h10;

    // FM gain picked by the effect level, entry 0 is the quietest
    localparam gain_t [3:0] OPN_GAIN_TABLE = {8'h30, 8'h28, 8'h20, 8'h18};

    localparam int DCRM_SHIFT = 6;   // default leak of the PSG average

    typedef struct packed {
        smp16_t  opn;
        smp16_t  opl;
        smp16_t  pcm;
        psg_ac_t psg;
    } mix_in_t;

    typedef struct packed {
        gain_t g0;   // opn
        gain_t g1;   // opl
        gain_t g2;   // pcm
        gain_t g3;   // psg
    } mix_gain_t;

endpackage

/* hdl/pcm_upsampler.sv */
/* Doubles the ADPCM sample rate by linear interpolation.
   Emits the midpoint right after each input strobe, the new sample half a period later. */
module pcm_upsampler (
    input  logic            clk,
    input  logic            rst,
    input  logic            sample_in,
    input  snd_pkg::pcm14_t din,
    output snd_pkg::smp16_t dout,
    output logic            up
);
    import snd_pkg::*;

    localparam int CNT_W = 12;   // covers a full ADPCM period at the system clock

    pcm14_t             last;       // previous input sample
    logic [CNT_W-1:0]   cnt;        // clocks since the last strobe
    logic [CNT_W-1:0]   half_cnt;   // countdown to the second output
    logic [CNT_W-1:0]   half;
    logic               pend;
    smp16_t             mid;

    always_comb begin
        mid  = smp16_t'((last + din) * 2);             // (4*last + 4*din) / 2
        half = CNT_W'(({1'b0, cnt} + 1'b1) >> 1);      // interval is cnt+1 clocks
        if (half == '0) begin
            half = 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last     <= '0;
            cnt      <= '0;
            half_cnt <= '0;
            pend     <= 1'b0;
            dout     <= '0;
            up       <= 1'b0;
        end else begin
            up <= 1'b0;
            if (!(&cnt)) begin
                cnt <= cnt + 1'b1;   // saturate on long gaps
            end
            if (sample_in) begin
                last     <= din;
                cnt      <= '0;
                dout     <= mid;
                up       <= 1'b1;
                half_cnt <= half;
                pend     <= 1'b1;
            end else if (pend) begin
                half_cnt <= half_cnt - 1'b1;
                if (half_cnt == 1) begin
                    dout <= {last, 2'b00};   // new sample, scaled by 4
                    up   <= 1'b1;
                    pend <= 1'b0;
                end
            end
        end
    end

endmodule

/* hdl/dc_remover.sv */
/* Removes the DC bias of the unsigned PSG stream with a leaky running average.
   Output is the signed AC part, updated on each cen. */
module dc_remover #(
    parameter int DCRM_SHIFT = snd_pkg::DCRM_SHIFT
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  snd_pkg::psg10_t  din,
    output snd_pkg::psg_ac_t dout
);
    import snd_pkg::*;

    localparam int IW = $bits(psg10_t);
    localparam int AW = IW + DCRM_SHIFT;   // integer plus fraction bits

    logic [AW-1:0]      avg;    // running average, unsigned fixed point
    logic signed [AW:0] diff;
    logic signed [AW:0] step;
    psg_ac_t            ac;

    always_comb begin
        diff = $signed({1'b0, din, {DCRM_SHIFT{1'b0}}}) - $signed({1'b0, avg});
        step = diff >>> DCRM_SHIFT;
        // integer part of the old average
        ac   = $signed({1'b0, din}) - $signed({1'b0, avg[AW-1 -: IW]});
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            avg  <= '0;
            dout <= '0;
        end else if (cen) begin
            dout <= ac;
            avg  <= AW'($signed({1'b0, avg}) + step);   // stays within 0..1023
        end
    end

endmodule

/* hdl/snd_mixer.sv */
/* Four-channel mixer with 4.4 fixed point gains.
   The sum is scaled back by 16, clamped to 16 bits, and peak flags a clamp. */
module snd_mixer (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  snd_pkg::mix_in_t   ch,
    input  snd_pkg::mix_gain_t gain,
    output snd_pkg::smp16_t    snd,
    output logic               sample,
    output logic               peak
);
    import snd_pkg::*;

    localparam int GW  = $bits(gain_t) + 1;       // gain as a positive signed value
    localparam int PW  = $bits(smp16_t) + GW;     // wide channel product
    localparam int QW  = $bits(psg_ac_t) + GW;    // psg product
    localparam int SW  = PW + 2;                  // room for four terms
    localparam int SCW = SW - 4;                  // after removing the gain fraction
    localparam int OW  = $bits(smp16_t);

    logic signed [GW-1:0]  g0;
    logic signed [GW-1:0]  g1;
    logic signed [GW-1:0]  g2;
    logic signed [GW-1:0]  g3;
    logic signed [PW-1:0]  p_opn;
    logic signed [PW-1:0]  p_opl;
    logic signed [PW-1:0]  p_pcm;
    logic signed [QW-1:0]  p_psg;
    logic signed [SW-1:0]  sum;
    logic signed [SCW-1:0] scaled;
    logic                  sat_hi;
    logic                  sat_lo;
    smp16_t                clamped;

    always_comb begin
        g0 = $signed({1'b0, gain.g0});
        g1 = $signed({1'b0, gain.g1});
        g2 = $signed({1'b0, gain.g2});
        g3 = $signed({1'b0, gain.g3});

        p_opn = $signed(ch.opn) * g0;
        p_opl = $signed(ch.opl) * g1;
        p_pcm = $signed(ch.pcm) * g2;
        p_psg = $signed(ch.psg) * g3;

        sum    = p_opn + p_opl + p_pcm + p_psg;
        scaled = SCW'(sum >>> 4);   // drop the 4.4 fraction

        // out of range when the bits above bit 15 disagree with the sign
        sat_hi = !scaled[SCW-1] && (|scaled[SCW-2:OW-1]);
        sat_lo =  scaled[SCW-1] && !(&scaled[SCW-2:OW-1]);

        if (sat_hi) begin
            clamped = {1'b0, {(OW-1){1'b1}}};   // 32767
        end else if (sat_lo) begin
            clamped = {1'b1, {(OW-1){1'b0}}};   // -32768
        end else begin
            clamped = scaled[OW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snd    <= '0;
            peak   <= 1'b0;
            sample <= 1'b0;
        end else begin
            sample <= cen;   // one pulse per mixed sample
            if (cen) begin
                snd  <= clamped;
                peak <= sat_hi | sat_lo;
            end
        end
    end

endmodule

/* hdl/snd_gen.sv */
/* Sound board top level: divides the ADPCM clock enable, selects channel gains,
   conditions the PCM and PSG streams and mixes all four channels. */
module snd_gen #(
    parameter int DCRM_SHIFT = snd_pkg::DCRM_SHIFT
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen_opn,
    input  logic            cen_opl,
    input  logic            enable_psg,
    input  logic            enable_fm,
    input  logic [1:0]      fxlevel,
    input  snd_pkg::smp16_t opn_snd,
    input  snd_pkg::smp16_t opl_snd,
    input  snd_pkg::psg10_t psg_snd,
    input  snd_pkg::pcm14_t oki_snd,
    input  logic            oki_sample,
    output logic            cen_oki,
    output snd_pkg::smp16_t snd,
    output logic            sample,
    output logic            peak
);
    import snd_pkg::*;

    logic [2:0] cen_sh;     // one-hot ring, advances on cen_opl
    mix_gain_t  gain_r;
    mix_in_t    ch;
    smp16_t     pcm_up;
    psg_ac_t    psg_ac;

    // ADPCM enable at a third of the OPL rate
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_sh  <= 3'b001;
            cen_oki <= 1'b0;
        end else begin
            if (cen_opl) begin
                cen_sh <= {cen_sh[1:0], cen_sh[2]};
            end
            cen_oki <= cen_sh[0] & cen_opl;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gain_r <= '0;
        end else begin
            gain_r.g0 <= enable_psg ? OPN_GAIN_TABLE[fxlevel] : '0;
            gain_r.g1 <= enable_fm ? OPL_GAIN : '0;
            gain_r.g2 <= PCM_GAIN;
            gain_r.g3 <= PSG_GAIN;
        end
    end

    always_comb begin
        ch.opn = opn_snd;
        ch.opl = opl_snd;
        ch.pcm = pcm_up;
        ch.psg = psg_ac;
    end

    pcm_upsampler u_pcm (
        .clk       (clk),
        .rst       (rst),
        .sample_in (oki_sample),
        .din       (oki_snd),
        .dout      (pcm_up),
        .up        ()            // mixer samples on cen_opn instead
    );

    dc_remover #(.DCRM_SHIFT(DCRM_SHIFT)) u_dcrm (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen_opn),
        .din  (psg_snd),
        .dout (psg_ac)
    );

    snd_mixer u_mixer (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen_opn),
        .ch     (ch),
        .gain   (gain_r),
        .snd    (snd),
        .sample (sample),
        .peak   (peak)
    );

endmodule

/* dv/snd_ref.svh */
/* Reference models for the sound board checks, included inside the testbench module.
   Gain table, PSG DC remover step, ADPCM midpoint and the saturating mix. */
`ifndef SND_REF_SVH
`define SND_REF_SVH

// FM gain for an effect level, 4.4 fixed point
function automatic longint opn_gain_of(logic en, logic [1:0] lvl);
    if (!en) begin
        return 0;
    end
    case (lvl)
        2'd0:    return 'h18;
        2'd1:    return 'h20;
        2'd2:    return 'h28;
        default: return 'h30;
    endcase
endfunction

// AC output, taken at the integer part of the old average
function automatic longint psg_ac_of(longint din, longint avg, int sh);
    return din - (avg >>> sh);
endfunction

// average kept with sh fraction bits
function automatic longint avg_next(longint din, longint avg, int sh);
    return avg + (((din <<< sh) - avg) >>> sh);
endfunction

function automatic longint midpoint(longint prev, longint cur);
    return (4 * prev + 4 * cur) / 2;   // always even, so exact
endfunction

// weighted sum with the gain fraction removed, floor rounding
function automatic longint mix_sum(longint opn, longint opl, longint pcm, longint psg,
                                   longint g0, longint g1, longint g2, longint g3);
    return (opn * g0 + opl * g1 + pcm * g2 + psg * g3) >>> 4;
endfunction

function automatic longint clamp16(longint v);
    if (v > 32767) return 32767;
    if (v < -32768) return -32768;
    return v;
endfunction

`endif

/* dv/snd_gen_tb.sv */
/* Testbench for the sound board top level.
   Drives the sample streams, models every channel and checks each mixed sample. */
module snd_gen_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import snd_pkg::*;
    `include "snd_ref.svh"

    localparam int SHIFT = 6;

    logic clk, rst, cen_opn, cen_opl, enable_psg, enable_fm, oki_sample;
    logic [1:0] fxlevel;
    smp16_t opn_snd, opl_snd, snd;
    psg10_t psg_snd;
    pcm14_t oki_snd;
    logic cen_oki, sample, peak;

    int seed = 85161;
    int tick;
    int errors, checks;
    longint exp_q[$];
    bit peak_q[$];
    // channel models as the mixer sees them
    longint g0_m, g1_m, psg_m, avg_m, pcm_m, prev_m, cnt_m, left_m;
    bit pend_m, oki_exp, sample_exp;
    int opl_cnt;

    snd_gen #(.DCRM_SHIFT(SHIFT)) uut (
        .clk(clk), .rst(rst), .cen_opn(cen_opn), .cen_opl(cen_opl),
        .enable_psg(enable_psg), .enable_fm(enable_fm), .fxlevel(fxlevel),
        .opn_snd(opn_snd), .opl_snd(opl_snd), .psg_snd(psg_snd), .oki_snd(oki_snd),
        .oki_sample(oki_sample), .cen_oki(cen_oki), .snd(snd), .sample(sample), .peak(peak)
    );

    initial begin
        clk = 0;
        forever #20 clk = ~clk;
    end

    // strobes: opn every 4 clocks, opl every 2, ADPCM every 24
    always @(posedge clk) begin
        tick       <= tick + 1;
        cen_opn    <= (tick % 4 == 0);
        cen_opl    <= (tick % 2 == 0);
        oki_sample <= (tick % 24 == 5);
    end

    always @(posedge clk) begin : compare
        longint s;
        longint e;
        bit ep;
        if (rst) begin
            exp_q.delete();
            peak_q.delete();
            {g0_m, g1_m, psg_m, avg_m, pcm_m, prev_m, cnt_m, left_m} = '0;
            pend_m = 0;
            oki_exp = 0;
            sample_exp = 0;
            opl_cnt = 0;
        end else begin
            if (cen_oki !== oki_exp) begin
                $display("[ERROR] %0t: cen_oki is %b, expected %b", $time, cen_oki, oki_exp);
                errors++;
            end
            if (sample !== sample_exp) begin
                $display("[ERROR] %0t: sample is %b, expected %b", $time, sample, sample_exp);
                errors++;
            end
            if (sample) begin
                if (exp_q.size() == 0) begin
                    $display("sample pulse at %0t with no mixed sample pending", $time);
                    errors++;
                end else begin
                    e  = exp_q.pop_front();
                    ep = peak_q.pop_front();
                    checks++;
                    if (longint'(snd) != e || peak !== ep) begin
                        $display("[ERROR] %0t: snd %0d peak %b, expected %0d peak %b",
                                 $time, snd, peak, e, ep);
                        errors++;
                    end
                end
            end
            sample_exp = cen_opn;   // mixed sample is valid one clock later
            oki_exp = cen_opl && (opl_cnt % 3 == 0);
            if (cen_opl) opl_cnt++;
            if (cen_opn) begin
                s = mix_sum(longint'(opn_snd), longint'(opl_snd), pcm_m, psg_m,
                            g0_m, g1_m, 16, 16);
                exp_q.push_back(clamp16(s));
                peak_q.push_back(s != clamp16(s));
                psg_m = psg_ac_of(longint'(psg_snd), avg_m, SHIFT);
                avg_m = avg_next(longint'(psg_snd), avg_m, SHIFT);
            end
            // upsampler: midpoint now, new sample half an interval later
            if (oki_sample) begin
                left_m = (cnt_m + 1) / 2;
                if (left_m == 0) left_m = 1;
                pcm_m  = midpoint(prev_m, longint'(oki_snd));
                prev_m = longint'(oki_snd);
                cnt_m  = 0;
                pend_m = 1;
            end else begin
                if (cnt_m < 4095) cnt_m++;
                if (pend_m) begin
                    left_m--;
                    if (left_m == 0) begin
                        pcm_m  = 4 * prev_m;
                        pend_m = 0;
                    end
                end
            end
            g0_m = opn_gain_of(enable_psg, fxlevel);
            g1_m = enable_fm ? 16 : 0;
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic wait_samples(int n);
        int seen;
        int cyc;
        seen = 0;
        cyc  = 0;
        while (seen < n) begin
            @(posedge clk);
            if (sample) seen++;
            cyc++;
            if (cyc > n * 4 + 50) abort_run("timeout waiting for mixed samples");
        end
    endtask

    task automatic report(string name, int e0);
        $display("%s: %s (errors %0d)", name, (errors == e0) ? "ok" : "FAIL", errors - e0);
    endtask

    initial begin : run
        int e0;
        int opl_seen;
        int oki_seen;
        int cyc;
        rst = 1;
        tick = 0;
        cen_opn = 0;
        cen_opl = 0;
        oki_sample = 0;
        enable_psg = 0;
        enable_fm = 0;
        fxlevel = 0;
        opn_snd = 0;
        opl_snd = 0;
        psg_snd = 0;
        oki_snd = 0;
        errors = 0;
        checks = 0;
        repeat (3) @(posedge clk);
        rst <= 0;

        e0 = errors;   // divider over 30 OPL enables
        opl_seen = 0;
        oki_seen = 0;
        cyc = 0;
        while (opl_seen < 31) begin
            @(posedge clk);
            if (cen_oki && opl_seen > 0 && opl_seen <= 30) oki_seen++;
            if (cen_opl) opl_seen++;
            cyc++;
            if (cyc > 200) abort_run("timeout waiting for cen_opl pulses");
        end
        if (oki_seen != 10) begin
            $display("[ERROR] %0t: %0d cen_oki pulses, expected 10", $time, oki_seen);
            errors++;
        end
        report("adpcm enable divider", e0);

        e0 = errors;
        @(posedge clk) enable_psg <= 1;
        for (int lvl = 0; lvl < 4; lvl++) begin
            @(posedge clk);
            fxlevel <= 2'(lvl);
            opn_snd <= smp16_t'($random(seed));
            wait_samples(4);
        end
        @(posedge clk) enable_psg <= 0;
        wait_samples(4);
        @(posedge clk);
        opn_snd   <= 0;
        opl_snd   <= smp16_t'($random(seed));
        enable_fm <= 1;
        wait_samples(4);
        @(posedge clk) enable_fm <= 0;
        wait_samples(4);
        report("gain table and enables", e0);

        e0 = errors;
        @(posedge clk);
        {enable_psg, enable_fm, fxlevel} <= 4'b1111;
        opn_snd <= 32767;
        opl_snd <= 32767;
        wait_samples(3);
        if (snd != 32767 || !peak) begin
            $display("[ERROR] %0t: positive clamp gave %0d peak %b", $time, snd, peak);
            errors++;
        end
        @(posedge clk);
        opn_snd <= -32768;
        opl_snd <= -32768;
        wait_samples(3);
        if (snd != -32768 || !peak) begin
            $display("[ERROR] %0t: negative clamp gave %0d peak %b", $time, snd, peak);
            errors++;
        end
        @(posedge clk);
        opn_snd <= 100;
        opl_snd <= -50;
        wait_samples(3);
        if (peak) begin
            $display("[ERROR] %0t: peak set for small values", $time);
            errors++;
        end
        report("saturation and peak", e0);

        e0 = errors;
        @(posedge clk);
        {enable_psg, enable_fm, opn_snd, opl_snd} <= '0;
        psg_snd <= 600;
        wait_samples(60);
        report("psg dc removal", e0);

        e0 = errors;
        @(posedge clk) oki_snd <= 1000;
        wait_samples(30);
        @(posedge clk) oki_snd <= -3000;
        wait_samples(30);
        report("adpcm upsampling", e0);

        e0 = errors;
        @(posedge clk) {enable_psg, enable_fm} <= 2'b11;
        for (int i = 0; i < 80; i++) begin
            @(posedge clk);
            fxlevel <= 2'($random(seed));
            opn_snd <= smp16_t'($random(seed));
            opl_snd <= smp16_t'($random(seed));
            psg_snd <= psg10_t'($random(seed));
            oki_snd <= pcm14_t'($random(seed));
            wait_samples(1);
        end
        report("random mix", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+dv
hdl/snd_pkg.sv
hdl/pcm_upsampler.sv
hdl/dc_remover.sv
hdl/snd_mixer.sv
hdl/snd_gen.sv
dv/snd_gen_tb.sv

/* Makefile */
# Verilator simulation of the sound board testbench

VERILATOR ?= verilator
TOP       ?= snd_gen_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
